/* files.f */
+incdir+src
src/mcu_pkg.sv
src/intr_router.sv
src/power_domain_ctrl.sv
src/bank_retention_ctrl.sv
src/mcu_power_irq_top.sv
tb/tb_mcu_power_irq.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the power and interrupt fabric testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=sim_tb

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  --top-module tb_mcu_power_irq \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
  -f files.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "simulation finished without failures"
exit 0

/* tb/tb_mcu_power_irq.sv */
// testbench for the power and interrupt fabric
// clock, reset, switch-cell ack model, directed stimulus, assertion checks

`timescale 1ns/1ps

`include "mcu_settings.svh"

module tb_mcu_power_irq;

  localparam int ACK_TIMEOUT = 20;
  localparam int NUM_FAST_SRC = 14;

  logic clk_i;
  logic rst_n_i;
  logic core_sleep_i;
  logic debug_ndmreset_ni;
  logic cpu_pwr_gate_en_i;
  logic periph_pwr_gate_en_i;
  mcu_pkg::bank_mask_t bank_ret_en_i;
  logic cpu_subsystem_powergate_switch_ack_ni;
  logic peripheral_subsystem_powergate_switch_ack_ni;
  logic irq_software_i;
  logic irq_external_i;
  logic [3:0] timer_intr_i;
  logic dma_done_intr_i;
  logic spi_intr_i;
  logic spi_flash_intr_i;
  mcu_pkg::gpio_ao_intr_t gpio_ao_intr_i;
  logic irq_ack_i;
  mcu_pkg::irq_id_t irq_id_i;
  mcu_pkg::intr_vec_t intr_o;
  logic cpu_subsystem_powergate_switch_no;
  logic cpu_subsystem_powergate_iso_no;
  logic cpu_subsystem_rst_no;
  logic peripheral_subsystem_powergate_switch_no;
  logic peripheral_subsystem_powergate_iso_no;
  logic peripheral_subsystem_rst_no;
  logic peripheral_subsystem_clkgate_en_no;
  mcu_pkg::bank_mask_t memory_subsystem_clkgate_en_no;
  mcu_pkg::bank_mask_t memory_subsystem_banks_set_retentive_no;

  int seed;
  int ack_wait;
  int order [NUM_FAST_SRC];

  mcu_power_irq_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic fail_and_stop();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic mismatch_exit(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("error: %s is 0x%0h, expected 0x%0h", name, got, exp);
    fail_and_stop();
  endtask

  task automatic stall_exit(input string what);
    $display("timed out waiting for %s", what);
    fail_and_stop();
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else mismatch_exit(name, 32'(got), 32'(exp));
  endtask

  task automatic expect_vec(input string name, input mcu_pkg::intr_vec_t got,
                            input mcu_pkg::intr_vec_t exp);
    assert (got === exp) else mismatch_exit(name, got, exp);
  endtask

  function automatic mcu_pkg::intr_vec_t level_bits(input logic sw, input logic tmr,
                                                    input logic ext);
    mcu_pkg::intr_vec_t v;
    v = '0;
    v[`IRQ_SOFTWARE_BIT] = sw;
    v[`IRQ_TIMER_BIT] = tmr;
    v[`IRQ_EXTERNAL_BIT] = ext;
    return v;
  endfunction

  function automatic mcu_pkg::intr_vec_t fast_vec(input int pos);
    return mcu_pkg::intr_vec_t'(1) << (`FAST_INTR_BASE + pos);
  endfunction

  // inputs change 1 ns after the edge and checks run 2 ns later
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic settle();
    #2;
  endtask

  // drives the source pin of one fast field position with all others low
  task automatic set_fast_source(input int pos, input logic val);
    timer_intr_i     = 4'b0000;
    dma_done_intr_i  = 1'b0;
    spi_intr_i       = 1'b0;
    spi_flash_intr_i = 1'b0;
    gpio_ao_intr_i   = '0;
    if (val) begin
      if (pos < 3) timer_intr_i = 4'b0010 << pos;
      else if (pos == 3) dma_done_intr_i = 1'b1;
      else if (pos == 4) spi_intr_i = 1'b1;
      else if (pos == 5) spi_flash_intr_i = 1'b1;
      else gpio_ao_intr_i = mcu_pkg::gpio_ao_intr_t'(1) << (pos - 6);
    end
  endtask

  task automatic expect_cpu_pins(input logic sw, input logic iso, input logic rst);
    expect_bit("cpu_subsystem_powergate_switch_no", cpu_subsystem_powergate_switch_no, sw);
    expect_bit("cpu_subsystem_powergate_iso_no", cpu_subsystem_powergate_iso_no, iso);
    expect_bit("cpu_subsystem_rst_no", cpu_subsystem_rst_no, rst);
  endtask

  task automatic expect_bank0(input logic clk, input logic ret);
    expect_bit("memory_subsystem_clkgate_en_no[0]", memory_subsystem_clkgate_en_no[0], clk);
    expect_bit("memory_subsystem_banks_set_retentive_no[0]",
               memory_subsystem_banks_set_retentive_no[0], ret);
  endtask

  task automatic expect_all_on();
    expect_cpu_pins(1'b1, 1'b1, 1'b1);
    expect_bit("cpu clkgate_en_no", u_dut.u_cpu_pwr.clkgate_en_no, 1'b1);
    expect_bit("peripheral_subsystem_rst_no", peripheral_subsystem_rst_no, 1'b1);
    expect_bank0(1'b1, 1'b1);
  endtask

  // pulse one fast source, then ack a foreign id and the matching id
  task automatic run_fast_source(input int pos);
    next_cycle();
    set_fast_source(pos, 1'b1);
    settle();
    expect_vec("intr_o", intr_o, '0);
    next_cycle();
    set_fast_source(pos, 1'b0);
    settle();
    expect_vec("intr_o", intr_o, fast_vec(pos));
    next_cycle();
    irq_ack_i = 1'b1;
    irq_id_i  = mcu_pkg::irq_id_t'(`FAST_INTR_BASE + ((pos + 5) % `FAST_INTR_W));
    settle();
    expect_vec("intr_o", intr_o, fast_vec(pos));
    next_cycle();
    irq_id_i = mcu_pkg::irq_id_t'(`FAST_INTR_BASE + pos);
    settle();
    expect_vec("intr_o", intr_o, fast_vec(pos));
    next_cycle();
    irq_ack_i = 1'b0;
    settle();
    expect_vec("intr_o", intr_o, '0);
  endtask

  task automatic run_cpu_sleep_wake();
    int waited;
    next_cycle();
    cpu_pwr_gate_en_i = 1'b1;
    bank_ret_en_i     = mcu_pkg::bank_mask_t'(1);
    core_sleep_i      = 1'b1;
    settle();
    expect_cpu_pins(1'b1, 1'b1, 1'b1);
    next_cycle();
    settle();
    expect_cpu_pins(1'b1, 1'b0, 1'b1);
    expect_bank0(1'b0, 1'b1);
    next_cycle();
    settle();
    expect_cpu_pins(1'b1, 1'b0, 1'b0);
    expect_bank0(1'b0, 1'b0);
    next_cycle();
    settle();
    expect_cpu_pins(1'b0, 1'b0, 1'b0);
    waited = 0;
    while (cpu_subsystem_powergate_switch_ack_ni !== 1'b0) begin
      expect_cpu_pins(1'b0, 1'b0, 1'b0);
      if (waited == ACK_TIMEOUT) stall_exit("the switch-off acknowledge");
      next_cycle();
      settle();
      waited++;
    end
    next_cycle();
    settle();
    expect_bit("cpu clkgate_en_no", u_dut.u_cpu_pwr.clkgate_en_no, 1'b0);
    expect_cpu_pins(1'b0, 1'b0, 1'b0);
    // debug reset while the domain is off
    next_cycle();
    debug_ndmreset_ni = 1'b0;
    settle();
    expect_bit("peripheral_subsystem_rst_no", peripheral_subsystem_rst_no, 1'b0);
    next_cycle();
    debug_ndmreset_ni = 1'b1;
    settle();
    expect_cpu_pins(1'b0, 1'b0, 1'b0);
    // gpio 0 wakes everything up
    next_cycle();
    core_sleep_i = 1'b0;
    set_fast_source(6, 1'b1);
    settle();
    expect_cpu_pins(1'b0, 1'b0, 1'b0);
    next_cycle();
    set_fast_source(6, 1'b0);
    settle();
    expect_vec("intr_o", intr_o, fast_vec(6));
    expect_cpu_pins(1'b0, 1'b0, 1'b0);
    next_cycle();
    settle();
    expect_cpu_pins(1'b1, 1'b0, 1'b0);
    expect_bit("cpu clkgate_en_no", u_dut.u_cpu_pwr.clkgate_en_no, 1'b1);
    expect_bank0(1'b0, 1'b1);
    waited = 0;
    while (cpu_subsystem_powergate_switch_ack_ni !== 1'b1) begin
      expect_cpu_pins(1'b1, 1'b0, 1'b0);
      if (waited == ACK_TIMEOUT) stall_exit("the switch-on acknowledge");
      next_cycle();
      settle();
      waited++;
      if (waited == 1) expect_bank0(1'b1, 1'b1);
    end
    next_cycle();
    settle();
    expect_cpu_pins(1'b1, 1'b0, 1'b1);
    next_cycle();
    settle();
    expect_cpu_pins(1'b1, 1'b1, 1'b1);
    next_cycle();
    irq_ack_i = 1'b1;
    irq_id_i  = mcu_pkg::irq_id_t'(`FAST_INTR_BASE + 6);
    next_cycle();
    irq_ack_i = 1'b0;
    settle();
    expect_vec("intr_o", intr_o, '0);
    expect_all_on();
  endtask

  // switch-cell model whose ack follows the request after 1 to 6 cycles
  initial begin
    cpu_subsystem_powergate_switch_ack_ni = 1'b1;
    ack_wait = 0;
    forever begin
      @(posedge clk_i);
      #1;
      if (ack_wait == 0) begin
        if (cpu_subsystem_powergate_switch_no !== cpu_subsystem_powergate_switch_ack_ni) begin
          ack_wait = 1 + int'($unsigned($random(seed)) % 32'd6);
        end
      end else begin
        ack_wait = ack_wait - 1;
        if (ack_wait == 0) begin
          cpu_subsystem_powergate_switch_ack_ni = cpu_subsystem_powergate_switch_no;
        end
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (intr_o & 32'h0000_0888) == level_bits(irq_software_i, timer_intr_i[0], irq_external_i))
    else mismatch_exit("intr_o level bits", intr_o & 32'h0000_0888,
                       level_bits(irq_software_i, timer_intr_i[0], irq_external_i));

  // unused vector bits and fast bit 14 stay low
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (intr_o & ~32'h3fff_0888) == 32'h0)
    else mismatch_exit("intr_o unused bits", intr_o & ~32'h3fff_0888, 32'h0);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !debug_ndmreset_ni |-> !cpu_subsystem_rst_no && !peripheral_subsystem_rst_no)
    else mismatch_exit("{cpu_subsystem_rst_no, peripheral_subsystem_rst_no}",
                       32'({cpu_subsystem_rst_no, peripheral_subsystem_rst_no}), 32'h0);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    {peripheral_subsystem_powergate_switch_no, peripheral_subsystem_powergate_iso_no,
     peripheral_subsystem_clkgate_en_no, peripheral_subsystem_rst_no} ==
    {3'b111, debug_ndmreset_ni})
    else mismatch_exit("peripheral {switch_no, iso_no, clkgate_en_no, rst_no}",
                       32'({peripheral_subsystem_powergate_switch_no,
                            peripheral_subsystem_powergate_iso_no,
                            peripheral_subsystem_clkgate_en_no,
                            peripheral_subsystem_rst_no}),
                       32'({3'b111, debug_ndmreset_ni}));

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    memory_subsystem_clkgate_en_no[1] && memory_subsystem_banks_set_retentive_no[1])
    else mismatch_exit("bank 1 {clkgate_en_no, set_retentive_no}",
                       32'({memory_subsystem_clkgate_en_no[1],
                            memory_subsystem_banks_set_retentive_no[1]}), 32'h3);

  // switch holds low until the cells report off
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !cpu_subsystem_powergate_switch_no && cpu_subsystem_powergate_switch_ack_ni
    |=> !cpu_subsystem_powergate_switch_no)
    else mismatch_exit("cpu_subsystem_powergate_switch_no",
                       32'(cpu_subsystem_powergate_switch_no), 32'h0);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(cpu_subsystem_powergate_switch_no) |->
    !cpu_subsystem_powergate_iso_no && !cpu_subsystem_rst_no)
    else mismatch_exit("cpu {iso_no, rst_no}",
                       32'({cpu_subsystem_powergate_iso_no, cpu_subsystem_rst_no}), 32'h0);

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cpu_subsystem_powergate_iso_no) |->
    cpu_subsystem_powergate_switch_no && cpu_subsystem_rst_no)
    else mismatch_exit("cpu {switch_no, rst_no}",
                       32'({cpu_subsystem_powergate_switch_no, cpu_subsystem_rst_no}), 32'h3);

  initial begin
    int j;
    int tmp;
    seed = 28539;
    rst_n_i = 1'b0;
    core_sleep_i = 1'b0;
    debug_ndmreset_ni = 1'b1;
    cpu_pwr_gate_en_i = 1'b0;
    periph_pwr_gate_en_i = 1'b0;
    bank_ret_en_i = '0;
    peripheral_subsystem_powergate_switch_ack_ni = 1'b1;
    irq_software_i = 1'b0;
    irq_external_i = 1'b0;
    set_fast_source(0, 1'b0);
    irq_ack_i = 1'b0;
    irq_id_i = '0;
    // shuffled order of the fast sources
    for (int i = 0; i < NUM_FAST_SRC; i++) order[i] = i;
    for (int i = NUM_FAST_SRC - 1; i > 0; i--) begin
      j = int'($unsigned($random(seed)) % 32'(i + 1));
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    settle();
    expect_all_on();
    expect_vec("intr_o", intr_o, '0);
    // level interrupts show up in the same cycle
    next_cycle();
    irq_software_i = 1'b1;
    settle();
    expect_vec("intr_o", intr_o, level_bits(1'b1, 1'b0, 1'b0));
    next_cycle();
    irq_software_i = 1'b0;
    timer_intr_i = 4'b0001;
    settle();
    expect_vec("intr_o", intr_o, level_bits(1'b0, 1'b1, 1'b0));
    next_cycle();
    timer_intr_i = 4'b0000;
    irq_external_i = 1'b1;
    settle();
    expect_vec("intr_o", intr_o, level_bits(1'b0, 1'b0, 1'b1));
    next_cycle();
    irq_external_i = 1'b0;
    settle();
    expect_vec("intr_o", intr_o, '0);
    for (int i = 0; i < NUM_FAST_SRC; i++) run_fast_source(order[i]);
    // debug reset while both domains are on
    next_cycle();
    debug_ndmreset_ni = 1'b0;
    settle();
    expect_bit("cpu_subsystem_rst_no", cpu_subsystem_rst_no, 1'b0);
    expect_bit("peripheral_subsystem_rst_no", peripheral_subsystem_rst_no, 1'b0);
    next_cycle();
    debug_ndmreset_ni = 1'b1;
    settle();
    expect_all_on();
    run_cpu_sleep_wake();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* src/mcu_power_irq_top.sv */
// power and interrupt fabric top: router, cpu and peripheral sequencers,
// per-bank retention sequencers and the debug reset merge

`timescale 1ns/1ps

`include "mcu_settings.svh"

module mcu_power_irq_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   core_sleep_i,
  input  logic                   debug_ndmreset_ni,
  input  logic                   cpu_pwr_gate_en_i,
  input  logic                   periph_pwr_gate_en_i,
  input  mcu_pkg::bank_mask_t    bank_ret_en_i,
  input  logic                   cpu_subsystem_powergate_switch_ack_ni,
  input  logic                   peripheral_subsystem_powergate_switch_ack_ni,
  input  logic                   irq_software_i,
  input  logic                   irq_external_i,
  input  logic [3:0]             timer_intr_i,
  input  logic                   dma_done_intr_i,
  input  logic                   spi_intr_i,
  input  logic                   spi_flash_intr_i,
  input  mcu_pkg::gpio_ao_intr_t gpio_ao_intr_i,
  input  logic                   irq_ack_i,
  input  mcu_pkg::irq_id_t       irq_id_i,
  output mcu_pkg::intr_vec_t     intr_o,
  output logic                   cpu_subsystem_powergate_switch_no,
  output logic                   cpu_subsystem_powergate_iso_no,
  output logic                   cpu_subsystem_rst_no,
  output logic                   peripheral_subsystem_powergate_switch_no,
  output logic                   peripheral_subsystem_powergate_iso_no,
  output logic                   peripheral_subsystem_rst_no,
  output logic                   peripheral_subsystem_clkgate_en_no,
  output mcu_pkg::bank_mask_t    memory_subsystem_clkgate_en_no,
  output mcu_pkg::bank_mask_t    memory_subsystem_banks_set_retentive_no
);

  logic wake;
  logic cpu_subsystem_rst_n;
  logic peripheral_subsystem_rst_n;

  intr_router u_intr_router (
    .clk_i,
    .rst_n_i,
    .irq_software_i,
    .irq_external_i,
    .timer_intr_i,
    .dma_done_intr_i,
    .spi_intr_i,
    .spi_flash_intr_i,
    .gpio_ao_intr_i,
    .irq_ack_i,
    .irq_id_i,
    .intr_o,
    .wake_o(wake)
  );

  // cpu domain, the core clock is gated inside the cpu so no pin here
  power_domain_ctrl u_cpu_pwr (
    .clk_i,
    .rst_n_i,
    .gate_en_i    (cpu_pwr_gate_en_i),
    .core_sleep_i,
    .wake_i       (wake),
    .switch_ack_ni(cpu_subsystem_powergate_switch_ack_ni),
    .switch_no    (cpu_subsystem_powergate_switch_no),
    .iso_no       (cpu_subsystem_powergate_iso_no),
    .rst_no       (cpu_subsystem_rst_n),
    .clkgate_en_no()
  );

  power_domain_ctrl u_periph_pwr (
    .clk_i,
    .rst_n_i,
    .gate_en_i    (periph_pwr_gate_en_i),
    .core_sleep_i,
    .wake_i       (wake),
    .switch_ack_ni(peripheral_subsystem_powergate_switch_ack_ni),
    .switch_no    (peripheral_subsystem_powergate_switch_no),
    .iso_no       (peripheral_subsystem_powergate_iso_no),
    .rst_no       (peripheral_subsystem_rst_n),
    .clkgate_en_no(peripheral_subsystem_clkgate_en_no)
  );

  // one retention sequencer per ram bank
  for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
    bank_retention_ctrl u_bank_ret (
      .clk_i,
      .rst_n_i,
      .ret_en_i        (bank_ret_en_i[i]),
      .core_sleep_i,
      .wake_i          (wake),
      .clkgate_en_no   (memory_subsystem_clkgate_en_no[i]),
      .set_retentive_no(memory_subsystem_banks_set_retentive_no[i])
    );
  end

  // debug module reset pulls both domains into reset at once
  assign cpu_subsystem_rst_no        = cpu_subsystem_rst_n & debug_ndmreset_ni;
  assign peripheral_subsystem_rst_no = peripheral_subsystem_rst_n & debug_ndmreset_ni;

endmodule

/* src/bank_retention_ctrl.sv */
// clock-gate and retention sequencer for one memory bank

`timescale 1ns/1ps

module bank_retention_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic ret_en_i,
  input  logic core_sleep_i,
  input  logic wake_i,
  output logic clkgate_en_no,
  output logic set_retentive_no
);

  mcu_pkg::bank_state_t state_q;
  mcu_pkg::bank_state_t state_d;

  logic clkgate_d;
  logic retentive_d;

  // gate first, then retain; wake undoes retention before the clock returns
  always_comb begin
    state_d = state_q;
    case (state_q)
      mcu_pkg::BANK_ACTIVE: begin
        if (ret_en_i && core_sleep_i && !wake_i) begin
          state_d = mcu_pkg::BANK_GATED;
        end
      end
      mcu_pkg::BANK_GATED: state_d = mcu_pkg::BANK_RETAINED;
      mcu_pkg::BANK_RETAINED: begin
        if (wake_i) begin
          state_d = mcu_pkg::BANK_UNGATE;
        end
      end
      mcu_pkg::BANK_UNGATE: state_d = mcu_pkg::BANK_ACTIVE;
      default: state_d = mcu_pkg::BANK_ACTIVE;
    endcase
  end

  // clock stays gated everywhere but active
  assign clkgate_d   = (state_d == mcu_pkg::BANK_ACTIVE);
  assign retentive_d = (state_d != mcu_pkg::BANK_RETAINED);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q          <= mcu_pkg::BANK_ACTIVE;
      clkgate_en_no    <= 1'b1;
      set_retentive_no <= 1'b1;
    end else begin
      state_q          <= state_d;
      clkgate_en_no    <= clkgate_d;
      set_retentive_no <= retentive_d;
    end
  end

endmodule

/* src/power_domain_ctrl.sv */
// power-gating sequencer for one switchable domain
// down: isolation, reset, switch, clock gate; up in the reverse order

`timescale 1ns/1ps

module power_domain_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic gate_en_i,
  input  logic core_sleep_i,
  input  logic wake_i,
  input  logic switch_ack_ni,
  output logic switch_no,
  output logic iso_no,
  output logic rst_no,
  output logic clkgate_en_no
);

  mcu_pkg::pwr_state_t state_q;
  mcu_pkg::pwr_state_t state_d;

  logic switch_d;
  logic iso_d;
  logic rst_d;
  logic clkgate_d;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      mcu_pkg::PWR_ON: begin
        if (gate_en_i && core_sleep_i && !wake_i) begin
          state_d = mcu_pkg::PWR_ISO;
        end
      end
      mcu_pkg::PWR_ISO: state_d = mcu_pkg::PWR_RST;
      mcu_pkg::PWR_RST: state_d = mcu_pkg::PWR_SW_OFF_WAIT;
      mcu_pkg::PWR_SW_OFF_WAIT: begin
        // switch cells report off with a low ack
        if (!switch_ack_ni) begin
          state_d = mcu_pkg::PWR_OFF;
        end
      end
      mcu_pkg::PWR_OFF: begin
        if (wake_i) begin
          state_d = mcu_pkg::PWR_SW_ON_WAIT;
        end
      end
      mcu_pkg::PWR_SW_ON_WAIT: begin
        if (switch_ack_ni) begin
          state_d = mcu_pkg::PWR_UNRST;
        end
      end
      mcu_pkg::PWR_UNRST: state_d = mcu_pkg::PWR_UNISO;
      mcu_pkg::PWR_UNISO: state_d = mcu_pkg::PWR_ON;
      default: state_d = mcu_pkg::PWR_ON;
    endcase
  end

  // output levels of the state being entered
  always_comb begin
    switch_d  = 1'b1;
    iso_d     = 1'b1;
    rst_d     = 1'b1;
    clkgate_d = 1'b1;
    case (state_d)
      mcu_pkg::PWR_ISO: begin
        iso_d = 1'b0;
      end
      mcu_pkg::PWR_RST, mcu_pkg::PWR_SW_ON_WAIT: begin
        iso_d = 1'b0;
        rst_d = 1'b0;
      end
      mcu_pkg::PWR_SW_OFF_WAIT: begin
        iso_d    = 1'b0;
        rst_d    = 1'b0;
        switch_d = 1'b0;
      end
      mcu_pkg::PWR_OFF: begin
        iso_d     = 1'b0;
        rst_d     = 1'b0;
        switch_d  = 1'b0;
        clkgate_d = 1'b0;
      end
      mcu_pkg::PWR_UNRST: begin
        iso_d = 1'b0;
      end
      default: ;
    endcase
  end

  // pins come straight from flops, no decode glitches on the switch cells
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= mcu_pkg::PWR_ON;
      switch_no     <= 1'b1;
      iso_no        <= 1'b1;
      rst_no        <= 1'b1;
      clkgate_en_no <= 1'b1;
    end else begin
      state_q       <= state_d;
      switch_no     <= switch_d;
      iso_no        <= iso_d;
      rst_no        <= rst_d;
      clkgate_en_no <= clkgate_d;
    end
  end

endmodule

/* src/intr_router.sv */
// interrupt router: core vector assembly, sticky fast-interrupt pending bank
// with clear by acknowledged id, and the wake request

`timescale 1ns/1ps

`include "mcu_settings.svh"

module intr_router (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   irq_software_i,
  input  logic                   irq_external_i,
  input  logic [3:0]             timer_intr_i,
  input  logic                   dma_done_intr_i,
  input  logic                   spi_intr_i,
  input  logic                   spi_flash_intr_i,
  input  mcu_pkg::gpio_ao_intr_t gpio_ao_intr_i,
  input  logic                   irq_ack_i,
  input  mcu_pkg::irq_id_t       irq_id_i,
  output mcu_pkg::intr_vec_t     intr_o,
  output logic                   wake_o
);

  mcu_pkg::fast_intr_t fast_src;
  mcu_pkg::fast_intr_t ack_clr;
  mcu_pkg::fast_intr_t pending_q;

  // fast field layout, top bit tied low
  // timers 1..3, dma done, spi, spi flash, then the always-on gpios
  assign fast_src = {
    1'b0,
    gpio_ao_intr_i,
    spi_flash_intr_i,
    spi_intr_i,
    dma_done_intr_i,
    timer_intr_i[3],
    timer_intr_i[2],
    timer_intr_i[1]
  };

  // decode the acknowledged id into a one-hot clear of the fast field
  always_comb begin
    ack_clr = '0;
    for (int k = 0; k < `FAST_INTR_W; k++) begin
      if (irq_ack_i && (irq_id_i == mcu_pkg::irq_id_t'(`FAST_INTR_BASE + k))) begin
        ack_clr[k] = 1'b1;
      end
    end
  end

  // sticky pending bits
  // a new event in the ack cycle keeps its bit set
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= fast_src | (pending_q & ~ack_clr);
    end
  end

  // core vector, levels go straight through
  always_comb begin
    intr_o = '0;
    intr_o[`FAST_INTR_BASE +: `FAST_INTR_W] = pending_q;
    intr_o[`IRQ_SOFTWARE_BIT] = irq_software_i;
    intr_o[`IRQ_TIMER_BIT] = timer_intr_i[0];
    intr_o[`IRQ_EXTERNAL_BIT] = irq_external_i;
  end

  // any visible interrupt wakes the sequencers
  assign wake_o = |intr_o;

endmodule

/* src/mcu_pkg.sv */
// vector typedefs and sequencer state encodings shared by the fabric

`include "mcu_settings.svh"

package mcu_pkg;

  // interrupt side
  typedef logic [`INTR_W-1:0] intr_vec_t;
  typedef logic [`FAST_INTR_W-1:0] fast_intr_t;
  typedef logic [`IRQ_ID_W-1:0] irq_id_t;
  typedef logic [`GPIO_AO_W-1:0] gpio_ao_intr_t;

  // one bit per memory bank
  typedef logic [`NUM_BANKS-1:0] bank_mask_t;

  // domain power sequencer
  // down: on, iso, rst, switch off wait, off
  // up: switch on wait, unrst, uniso, back to on
  typedef enum logic [2:0] {PWR_ON, PWR_ISO, PWR_RST, PWR_SW_OFF_WAIT, PWR_OFF, PWR_SW_ON_WAIT, PWR_UNRST, PWR_UNISO} pwr_state_t;

  // memory bank sequencer
  typedef enum logic [1:0] {BANK_ACTIVE, BANK_GATED, BANK_RETAINED, BANK_UNGATE} bank_state_t;

endpackage

/* src/mcu_settings.svh */
// bank count, interrupt vector widths and fixed interrupt bit positions
// for the power and interrupt fabric

`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// memory banks with their own clock gate and retention control
`define NUM_BANKS 2

// core interrupt vector and the fast-interrupt field inside it
`define INTR_W 32
`define FAST_INTR_W 15
`define FAST_INTR_BASE 16

// width of the id the core returns on acknowledge
`define IRQ_ID_W 5

// level interrupts, riscv standard positions
`define IRQ_SOFTWARE_BIT 3
`define IRQ_TIMER_BIT 7
`define IRQ_EXTERNAL_BIT 11

// always-on gpio interrupt lines
`define GPIO_AO_W 8

`endif
